//--- verilog/aes_pkg.sv
// AES-128/192/256 encrypt-only definitions; the state union assumes a 128-bit block on a 32-bit bus
`default_nettype none

package aes_pkg;

  // ==========================================================
  // Widths and sizes
  // ==========================================================

  // One AES block, seen as sixteen bytes or four bus words
  localparam int state_bits = 128;
  localparam int bus_width  = 32;
  // Word address of the Wishbone window, enough for the key store at 64..123
  localparam int adr_width  = 7;
  // Key store holds four words per round key, up to fourteen rounds plus the initial key
  localparam int key_word_max = 60;

  // Byte 15 is the first byte of the block in FIPS order, word 3 is the first column
  typedef union packed {
    logic [15:0][7:0] bytes;
    logic [3:0][31:0] words;
  } aes_state_u;

  // ==========================================================
  // Register map (word addresses)
  // ==========================================================

  localparam logic [adr_width-1:0] reg_ctrl        = 'd0;
  localparam logic [adr_width-1:0] reg_status      = 'd1;
  localparam logic [adr_width-1:0] reg_plain_base  = 'd4;
  localparam logic [adr_width-1:0] reg_cipher_base = 'd8;
  localparam logic [adr_width-1:0] reg_key_base    = 'd64;

  // ==========================================================
  // Forward S-box, entry 0 first
  // ==========================================================

  localparam logic [0:255][7:0] sbox = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5, 8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0, 8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc, 8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a, 8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0, 8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b, 8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85, 8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5, 8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17, 8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88, 8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c, 8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9, 8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6, 8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e, 8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94, 8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68, 8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Multiply by x in GF(2^8), folding the carry back with the AES polynomial
  function automatic logic [7:0] gf_x2(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Multiply by x+1, which is the doubled byte plus the byte itself
  function automatic logic [7:0] gf_x3(input logic [7:0] b);
    return gf_x2(b) ^ b;
  endfunction

endpackage

`default_nettype wire

//--- verilog/aes_round_logic.sv
// Purely combinational round; the caller must hold last_round high only for the final round
`timescale 1ns/1ns
`default_nettype none

module aes_round_logic (
  input  aes_pkg::aes_state_u round_in,
  input  aes_pkg::aes_state_u round_key,
  input  logic                last_round,
  output aes_pkg::aes_state_u round_out
);
  import aes_pkg::*;

  aes_state_u            shifted;
  aes_state_u            mixed;
  logic [state_bits-1:0] pre_key;

  // SubBytes and ShiftRows in one pass
  // Byte k of the block (FIPS order) sits at row k%4, column k/4, and at bit lane 15-k
  // Row r is rotated left by r columns, so output (r,c) takes input (r,(c+r)%4)
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[15 - (4 * c + r)] = sbox[round_in.bytes[15 - (4 * ((c + r) % 4) + r)]];
      end
    end
  end

  // MixColumns, one column at a time with the fixed 2-3-1-1 circulant matrix
  always_comb begin
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    for (int c = 0; c < 4; c++) begin
      // a0 is row 0 of the column, which is the top byte of that bus word
      a0 = shifted.bytes[15 - 4 * c];
      a1 = shifted.bytes[14 - 4 * c];
      a2 = shifted.bytes[13 - 4 * c];
      a3 = shifted.bytes[12 - 4 * c];
      mixed.bytes[15 - 4 * c] = gf_x2(a0) ^ gf_x3(a1) ^ a2 ^ a3;
      mixed.bytes[14 - 4 * c] = a0 ^ gf_x2(a1) ^ gf_x3(a2) ^ a3;
      mixed.bytes[13 - 4 * c] = a0 ^ a1 ^ gf_x2(a2) ^ gf_x3(a3);
      mixed.bytes[12 - 4 * c] = gf_x3(a0) ^ a1 ^ a2 ^ gf_x2(a3);
    end
  end

  // The final round leaves MixColumns out
  assign pre_key = last_round ? shifted : mixed;

  // AddRoundKey, both operands share the same column-major layout
  assign round_out = pre_key ^ round_key;

endmodule

`default_nettype wire

//--- verilog/aes_round_keys.sv
// Key words are written pre-expanded by software; contents are undefined until written, no reset
`timescale 1ns/1ns
`default_nettype none

module aes_round_keys #(
  parameter int num_rounds = 10
) (
  input  logic                          eph1,
  input  logic                          key_we,
  input  logic [5:0]                    key_addr,
  input  logic [aes_pkg::bus_width-1:0] key_data,
  input  logic [3:0]                    round_idx,
  output aes_pkg::aes_state_u           round_key
);
  import aes_pkg::*;

  // Initial key plus one key per round, four columns each
  localparam int key_words = 4 * (num_rounds + 1);

  logic [bus_width-1:0] key_mem [key_words];

  // Single write port from the bus, address range already checked upstream
  always_ff @(posedge eph1) begin
    if (key_we) begin
      key_mem[key_addr] <= key_data;
    end
  end

  // Word 4r+c is column c of round key r, column 0 goes to the top word
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      round_key.words[3 - c] = key_mem[{round_idx, 2'(c)}];
    end
  end

endmodule

`default_nettype wire

//--- verilog/aes_regs.sv
// Wishbone classic slave, two clocks per access, no errors; plaintext and key writes dropped while busy
`timescale 1ns/1ns
`default_nettype none

module aes_regs #(
  parameter int num_rounds = 10
) (
  input  logic                          eph1,
  input  logic                          arst_n,
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  logic [aes_pkg::adr_width-1:0] adr,
  input  logic [aes_pkg::bus_width-1:0] dat_w,
  input  logic                          busy,
  input  logic                          done,
  input  aes_pkg::aes_state_u           state,
  output logic [aes_pkg::bus_width-1:0] dat_r,
  output logic                          ack,
  output logic                          start,
  output aes_pkg::aes_state_u           plain,
  output logic                          key_we,
  output logic [5:0]                    key_addr,
  output logic [aes_pkg::bus_width-1:0] key_data
);
  import aes_pkg::*;

  localparam int block_words = state_bits / bus_width;
  localparam int key_words   = 4 * (num_rounds + 1);

  logic                 wr_fire;
  logic                 hit_plain;
  logic                 hit_cipher;
  logic                 hit_key;
  logic [adr_width-1:0] plain_off;
  logic [adr_width-1:0] cipher_off;
  logic [adr_width-1:0] key_off;
  logic [bus_width-1:0] rd_data;

  // ==========================================================
  // Bus handshake
  // ==========================================================

  // Ack comes one clock after cyc and stb, and drops on the clock after
  always_ff @(posedge eph1 or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= cyc && stb && !ack;
    end
  end

  // Writes take effect at the end of the ack cycle
  assign wr_fire = cyc && stb && we && ack;

  // Offsets into each window; an address below a base wraps high and misses
  assign plain_off  = adr - reg_plain_base;
  assign cipher_off = adr - reg_cipher_base;
  assign key_off    = adr - reg_key_base;
  assign hit_plain  = plain_off < block_words;
  assign hit_cipher = cipher_off < block_words;
  assign hit_key    = key_off < key_word_max;

  // ==========================================================
  // Write side
  // ==========================================================

  // Start is only honoured when the engine is idle
  assign start = wr_fire && (adr == reg_ctrl) && dat_w[0] && !busy;

  // Key words past the last round key of this build are dropped
  assign key_we   = wr_fire && !busy && hit_key && (key_off < key_words);
  assign key_addr = key_off[5:0];
  assign key_data = dat_w;

  // Plaintext window holds the most significant word at the lowest address
  always_ff @(posedge eph1 or negedge arst_n) begin
    if (!arst_n) begin
      plain <= '0;
    end else if (wr_fire && !busy && hit_plain) begin
      plain.words[2'd3 - plain_off[1:0]] <= dat_w;
    end
  end

  // ==========================================================
  // Read side
  // ==========================================================

  // Control and key store are write-only and read as zero like any hole
  always_comb begin
    rd_data = '0;
    if (adr == reg_status) begin
      rd_data[1:0] = {done, busy};
    end else if (hit_plain) begin
      rd_data = plain.words[2'd3 - plain_off[1:0]];
    end else if (hit_cipher) begin
      rd_data = state.words[2'd3 - cipher_off[1:0]];
    end
  end

  // Read data is captured as ack goes high and held through the ack cycle
  always_ff @(posedge eph1) begin
    if (cyc && stb && !ack) begin
      dat_r <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/aes_round_ctrl.sv
// One block in flight; start is ignored while running; done holds until the next start
`timescale 1ns/1ns
`default_nettype none

module aes_round_ctrl #(
  parameter int num_rounds = 10
) (
  input  logic                eph1,
  input  logic                arst_n,
  input  logic                start,
  input  aes_pkg::aes_state_u plain,
  input  aes_pkg::aes_state_u round_key,
  input  aes_pkg::aes_state_u round_out,
  output logic [3:0]          round_idx,
  output aes_pkg::aes_state_u round_in,
  output logic                last_round,
  output logic                busy,
  output logic                done,
  output aes_pkg::aes_state_u state
);
  import aes_pkg::*;

  localparam logic st_idle = 1'b0;
  localparam logic st_run  = 1'b1;

  logic                  fsm_q;
  logic [3:0]            round_cnt;
  logic                  load;
  logic [state_bits-1:0] state_d;

  // ==========================================================
  // Control
  // ==========================================================

  // The counter rests at 0 so the start cycle reads round key 0
  assign load       = (fsm_q == st_idle) && start;
  assign last_round = (fsm_q == st_run) && (round_cnt == 4'(num_rounds));
  assign busy       = (fsm_q == st_run);
  assign round_idx  = round_cnt;

  always_ff @(posedge eph1 or negedge arst_n) begin
    if (!arst_n) begin
      fsm_q     <= st_idle;
      round_cnt <= '0;
      done      <= 1'b0;
    end else if (load) begin
      fsm_q     <= st_run;
      round_cnt <= 4'd1;
      done      <= 1'b0;
    end else if (last_round) begin
      // The final update lands on this same edge
      fsm_q     <= st_idle;
      round_cnt <= '0;
      done      <= 1'b1;
    end else if (fsm_q == st_run) begin
      round_cnt <= round_cnt + 4'd1;
    end
  end

  // ==========================================================
  // State register
  // ==========================================================

  // Initial AddRoundKey on load, then each round's output comes back around
  always_comb begin
    state_d = state;
    if (load) begin
      state_d = plain ^ round_key;
    end else if (fsm_q == st_run) begin
      state_d = round_out;
    end
  end

  always_ff @(posedge eph1 or negedge arst_n) begin
    if (!arst_n) begin
      state <= '0;
    end else begin
      state <= state_d;
    end
  end

  // the round logic always works on the registered state
  assign round_in = state;

endmodule

`default_nettype wire

//--- verilog/aes_top.sv
// Encrypt-only AES on Wishbone; num_rounds must be 10, 12 or 14 to match the loaded key schedule
`timescale 1ns/1ns
`default_nettype none

module aes_top #(
  parameter int num_rounds = 10
) (
  input  logic                          eph1,
  input  logic                          arst_n,
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  logic [aes_pkg::adr_width-1:0] adr,
  input  logic [aes_pkg::bus_width-1:0] dat_w,
  output logic [aes_pkg::bus_width-1:0] dat_r,
  output logic                          ack
);
  import aes_pkg::*;

  // Register block to key store and controller
  logic                 start;
  aes_state_u           plain;
  logic                 key_we;
  logic [5:0]           key_addr;
  logic [bus_width-1:0] key_data;

  // Controller to key store and round logic
  logic [3:0]           round_idx;
  aes_state_u           round_key;
  aes_state_u           round_in;
  aes_state_u           round_out;
  logic                 last_round;

  // Controller back to the register block
  logic                 busy;
  logic                 done;
  aes_state_u           state;

  aes_regs #(.num_rounds(num_rounds)) u_regs (
    .eph1(eph1), .arst_n(arst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .busy(busy), .done(done), .state(state), .dat_r(dat_r), .ack(ack),
    .start(start), .plain(plain), .key_we(key_we), .key_addr(key_addr), .key_data(key_data)
  );

  aes_round_keys #(.num_rounds(num_rounds)) u_round_keys (
    .eph1(eph1), .key_we(key_we), .key_addr(key_addr), .key_data(key_data),
    .round_idx(round_idx), .round_key(round_key)
  );

  aes_round_ctrl #(.num_rounds(num_rounds)) u_round_ctrl (
    .eph1(eph1), .arst_n(arst_n), .start(start), .plain(plain), .round_key(round_key),
    .round_out(round_out), .round_idx(round_idx), .round_in(round_in),
    .last_round(last_round), .busy(busy), .done(done), .state(state)
  );

  aes_round_logic u_round_logic (
    .round_in(round_in), .round_key(round_key), .last_round(last_round),
    .round_out(round_out)
  );

endmodule

`default_nettype wire

//--- testbench/tb_aes_top.sv
// Run from the project root so the trace path resolves; built for num_rounds 10 and AES-128 vectors
`timescale 1ns/1ns
`default_nettype none

module tb_aes_top;

  // Word addresses used by the sequencer itself
  localparam logic [6:0] ctrl_adr   = 7'h00;
  localparam logic [6:0] status_adr = 7'h01;

  logic        eph1;
  logic        arst_n;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [6:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;

  // Trace records, one entry per bus operation
  logic [7:0]  op_q   [$];
  logic [6:0]  adr_q  [$];
  logic [31:0] data_q [$];

  int          checks;
  int          errors;
  int          other_errors;
  int          limit;
  int          cycle_count;

  aes_top #(.num_rounds(10)) dut (
    .eph1(eph1), .arst_n(arst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
  );

  // ==========================================================
  // Clock and watchdog
  // ==========================================================

  initial begin
    eph1 = 1'b0;
    forever #10 eph1 = ~eph1;
  end

  // The limit is only known once the trace has been read
  initial begin : watchdog
    cycle_count = 0;
    wait (limit != 0);
    while (cycle_count < limit) begin
      @(posedge eph1);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Checks failed");
    $finish;
  end

  // ==========================================================
  // Trace reader
  // ==========================================================

  // Records are whitespace separated, so one line may hold several of them
  // A lone # token starts a comment that runs to the end of its line
  task automatic load_trace;
    int             fd;
    int             code;
    logic [63:0]    tok;
    logic [31:0]    a_val;
    logic [31:0]    d_val;
    logic [2047:0]  rest;
    fd = $fopen("testbench/aes_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file testbench/aes_trace.txt");
      other_errors = other_errors + 1;
    end else begin
      while (!$feof(fd)) begin
        tok  = '0;
        code = $fscanf(fd, "%s", tok);
        if (code == 1) begin
          if (tok == "#") begin
            code = $fgets(rest, fd);
          end else if (tok == "p") begin
            op_q.push_back(tok[7:0]);
            adr_q.push_back(7'h00);
            data_q.push_back(32'h0);
          end else if (tok == "w" || tok == "r") begin
            code = $fscanf(fd, "%h %h", a_val, d_val);
            if (code != 2) begin
              $display("Trace record %0d has a missing address or data field", op_q.size());
              other_errors = other_errors + 1;
            end
            op_q.push_back(tok[7:0]);
            adr_q.push_back(a_val[6:0]);
            data_q.push_back(d_val);
          end else begin
            $display("Trace holds an unknown record type '%0s'", tok);
            other_errors = other_errors + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ==========================================================
  // Wishbone master
  // ==========================================================

  // Entered and left 2 ns after a rising edge
  // Strobe is held through the ack cycle, the slave commits writes at its end
  task automatic bus_access(input logic wr, input logic [6:0] a, input logic [31:0] d,
                            output logic [31:0] q);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    @(posedge eph1);
    #2;
    while (ack !== 1'b1) begin
      @(posedge eph1);
      #2;
    end
    // Read data is stable for the whole ack cycle
    q = dat_r;
    @(posedge eph1);
    #2;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
  endtask

  // Status bit 1 is done
  task automatic poll_done;
    logic [31:0] q;
    q = '0;
    while (q[1] !== 1'b1) begin
      bus_access(1'b0, status_adr, 32'h0, q);
    end
  endtask

  // Whole idle clocks, each one left 2 ns after its rising edge
  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge eph1);
      #2;
    end
  endtask

  // ==========================================================
  // Sequencer
  // ==========================================================

  initial begin : main
    int unsigned gap;
    int          i;
    logic [31:0] rdata;
    logic        in_run;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    dat_w        = '0;
    arst_n       = 1'b0;
    in_run       = 1'b0;
    checks       = 0;
    errors       = 0;
    other_errors = 0;
    limit        = 0;
    gap          = $urandom(32'hc8b50320);
    load_trace();
    limit = 40 * op_q.size();
    repeat (5) @(posedge eph1);
    #2;
    arst_n = 1'b1;
    for (i = 0; i < op_q.size(); i++) begin
      // No gaps inside a run, so the busy-window accesses land before done
      if (!in_run) begin
        gap = $urandom % 4;
        idle_cycles(gap);
      end
      case (op_q[i])
        "w": begin
          bus_access(1'b1, adr_q[i], data_q[i], rdata);
          if (adr_q[i] == ctrl_adr && data_q[i][0]) begin
            in_run = 1'b1;
          end
        end
        "r": begin
          bus_access(1'b0, adr_q[i], 32'h0, rdata);
          checks = checks + 1;
          if (rdata !== data_q[i]) begin
            errors = errors + 1;
            $display("Error at %0t ns: read of adr 0x%h expected 0x%h, got 0x%h",
                     $time, adr_q[i], data_q[i], rdata);
          end
        end
        default: begin
          poll_done();
          in_run = 1'b0;
        end
      endcase
    end
    $display("Reads checked: %0d, read mismatches: %0d, other errors: %0d",
             checks, errors, other_errors);
    if (errors == 0 && other_errors == 0 && checks > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
verilog/aes_pkg.sv
verilog/aes_round_logic.sv
verilog/aes_round_keys.sv
verilog/aes_regs.sv
verilog/aes_round_ctrl.sv
verilog/aes_top.sv
testbench/tb_aes_top.sv

//--- testbench/aes_trace.txt
# Columns: op adr data, op is w (bus write), r (bus read, expect data) or p (poll until done)
# adr is a hex word address, data is 32-bit hex, p has no fields; several records may share a line
# Idle state after reset, key store and unmapped words read as zero
r 01 00000000
r 08 00000000 r 09 00000000 r 0a 00000000 r 0b 00000000
r 02 00000000 r 04 00000000 r 40 00000000
# Round keys for key 000102030405060708090a0b0c0d0e0f, one round key per line
w 40 00010203 w 41 04050607 w 42 08090a0b w 43 0c0d0e0f
w 44 d6aa74fd w 45 d2af72fa w 46 daa678f1 w 47 d6ab76fe
w 48 b692cf0b w 49 643dbdf1 w 4a be9bc500 w 4b 6830b3fe
w 4c b6ff744e w 4d d2c2c9bf w 4e 6c590cbf w 4f 0469bf41
w 50 47f7f7bc w 51 95353e03 w 52 f96c32bc w 53 fd058dfd
w 54 3caaa3e8 w 55 a99f9deb w 56 50f3af57 w 57 adf622aa
w 58 5e390f7d w 59 f7a69296 w 5a a7553dc1 w 5b 0aa31f6b
w 5c 14f9701a w 5d e35fe28c w 5e 440adf4d w 5f 4ea9c026
w 60 47438735 w 61 a41c65b9 w 62 e016baf4 w 63 aebf7ad2
w 64 549932d1 w 65 f0855768 w 66 1093ed9c w 67 be2c974e
w 68 13111d7f w 69 e3944a17 w 6a f307a78b w 6b 4d2b30c5
# Plaintext 00112233445566778899aabbccddeeff, then read back
w 04 00112233 w 05 44556677 w 06 8899aabb w 07 ccddeeff
r 04 00112233 r 05 44556677 r 06 8899aabb r 07 ccddeeff
# Start the run, status shows busy and not done
w 00 00000001
r 01 00000001
# Plaintext and last round key writes while busy must be dropped
w 04 deadbeef
w 6b 0badf00d
r 04 00112233
p
# FIPS-197 Appendix C.1 cipher
r 08 69c4e0d8 r 09 6a7b0430 r 0a d8cdb780 r 0b 70b4c55a
r 01 00000002
r 04 00112233
# Round keys for key 2b7e151628aed2a6abf7158809cf4f3c over the first schedule
w 40 2b7e1516 w 41 28aed2a6 w 42 abf71588 w 43 09cf4f3c
w 44 a0fafe17 w 45 88542cb1 w 46 23a33939 w 47 2a6c7605
w 48 f2c295f2 w 49 7a96b943 w 4a 5935807a w 4b 7359f67f
w 4c 3d80477d w 4d 4716fe3e w 4e 1e237e44 w 4f 6d7a883b
w 50 ef44a541 w 51 a8525b7f w 52 b671253b w 53 db0bad00
w 54 d4d1c6f8 w 55 7c839d87 w 56 caf2b8bc w 57 11f915bc
w 58 6d88a37a w 59 110b3efd w 5a dbf98641 w 5b ca0093fd
w 5c 4e54f70e w 5d 5f5fc9f3 w 5e 84a64fb2 w 5f 4ea6dc4f
w 60 ead27321 w 61 b58dbad2 w 62 312bf560 w 63 7f8d292f
w 64 ac7766f3 w 65 19fadc21 w 66 28d12941 w 67 575c006e
w 68 d014f9a8 w 69 c9ee2589 w 6a e13f0cc8 w 6b b6630ca6
# Plaintext 3243f6a8885a308d313198a2e0370734
w 04 3243f6a8 w 05 885a308d w 06 313198a2 w 07 e0370734
r 04 3243f6a8 r 07 e0370734
# A new start clears done
w 00 00000001
r 01 00000001
p
# FIPS-197 Appendix B cipher
r 08 3925841d r 09 02dc09fb r 0a dc118597 r 0b 196a0b32
r 01 00000002
